//--- include/uart16550_define.svh
`ifndef UART16550_DEFINE_SVH
`define UART16550_DEFINE_SVH

// ********************
// 16550 register offsets inside one 8 KB window
// ********************

// regs sit on 32-bit lanes above the 4 KB mark
`define UART_RBR 13'h1000 // rx buffer, read side
`define UART_THR 13'h1000 // tx holding, write side
`define UART_IER 13'h1004
`define UART_IIR 13'h1008 // read side
`define UART_FCR 13'h1008 // write side
`define UART_LCR 13'h100C
`define UART_MCR 13'h1010
`define UART_LSR 13'h1014
`define UART_MSR 13'h1018
`define UART_SCR 13'h101C

`endif

//--- hw/uart_snoop_pkg.sv
package uart_snoop_pkg;

	// ********************
	// address map
	// ********************

	// width of the snooped read address
	parameter int AXI_ADDR_W = 16;

	// one 8 KB window per UART
	parameter int UART_SEL_LSB = 13;
	parameter int UART_IDX_W = AXI_ADDR_W - UART_SEL_LSB;

	// ********************
	// magic sequence
	// ********************

	// byte 0 (8'h34) arrives first
	parameter logic [63:0] RESET_SEQUENCE = 64'h9a33_7213_af27_8f34;

	// matcher position, value equals the index of the next expected byte
	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		BYTE1   = 4'd1,
		BYTE2   = 4'd2,
		BYTE3   = 4'd3,
		BYTE4   = 4'd4,
		BYTE5   = 4'd5,
		BYTE6   = 4'd6,
		BYTE7   = 4'd7,
		MATCHED = 4'd8 // one cycle, drives seq_hit
	} seq_state_t;

endpackage

//--- hw/rbr_read_tracker.sv
`timescale 1ns/1ps
`include "uart16550_define.svh"

module rbr_read_tracker
	import uart_snoop_pkg::*;
#(
	parameter int NUM_UARTS = 4
) (
	input  logic                  axi_clk,
	input  logic                  axi_rst_n,

	input  logic [AXI_ADDR_W-1:0] axi_araddr,
	input  logic                  axi_arvalid,
	input  logic                  axi_arready,

	input  logic [31:0]           axi_rdata,
	input  logic                  axi_rvalid,
	input  logic                  axi_rready,

	output logic [7:0]            rx_byte,
	output logic [NUM_UARTS-1:0]  rx_strobe
);

	logic                  ar_go;
	logic                  r_go;
	logic [UART_IDX_W-1:0] ar_idx;
	logic                  rbr_hit;
	logic                  pending;
	logic [UART_IDX_W-1:0] pend_idx;
	logic                  rd_done;

	assign ar_go = axi_arvalid & axi_arready;
	assign r_go  = axi_rvalid & axi_rready;

	// ********************
	// address decode
	// ********************

	assign ar_idx = axi_araddr[AXI_ADDR_W-1:UART_SEL_LSB]; // window number

	// only RBR reads in a populated window count
	assign rbr_hit = ar_go
		&& (axi_araddr[UART_SEL_LSB-1:0] == `UART_RBR)
		&& (ar_idx < NUM_UARTS);

	assign rd_done = pending & r_go;

	// ********************
	// outstanding read
	// ********************

	always_ff @(posedge axi_clk) begin
		if (!axi_rst_n) begin
			pending <= 1'b0;
		end else if (pending) begin
			if (r_go)
				pending <= 1'b0;
		end else if (rbr_hit) begin
			pending <= 1'b1; // AR seen while pending is dropped
		end
	end

	always_ff @(posedge axi_clk) begin
		if (!pending && rbr_hit)
			pend_idx <= ar_idx;
	end

	// ********************
	// byte strobe, one cycle after R
	// ********************

	always_ff @(posedge axi_clk) begin
		if (!axi_rst_n) begin
			rx_strobe <= '0;
		end else if (rd_done) begin
			rx_strobe <= NUM_UARTS'(1) << pend_idx;
		end else begin
			rx_strobe <= '0;
		end
	end

	always_ff @(posedge axi_clk) begin
		if (rd_done)
			rx_byte <= axi_rdata[7:0]; // RBR data is the low lane
	end

	// every completed RBR read reaches exactly one UART
	a_strobe_onehot: assert property (@(posedge axi_clk) disable iff (!axi_rst_n)
		$onehot0(rx_strobe) && ((rx_strobe != '0) == $past(rd_done)));

endmodule

//--- hw/reset_seq_matcher.sv
`timescale 1ns/1ps

module reset_seq_matcher
	import uart_snoop_pkg::*;
(
	input  logic       axi_clk,
	input  logic       axi_rst_n,
	input  logic [7:0] rx_byte,
	input  logic       rx_valid,
	output logic       seq_hit
);

	seq_state_t state;
	seq_state_t next_state;
	logic [2:0] byte_idx;
	logic [7:0] exp_byte;

	// ********************
	// expected byte
	// ********************

	// MATCHED behaves like IDLE for the next byte
	assign byte_idx = state[2:0]; // MATCHED (8) wraps to 0
	assign exp_byte = RESET_SEQUENCE[{byte_idx, 3'b000} +: 8];

	// ********************
	// state machine
	// ********************

	always_comb begin
		next_state = (state == MATCHED) ? IDLE : state;
		if (rx_valid) begin
			if (rx_byte != exp_byte) begin
				// mismatch, no second look as byte 0
				next_state = IDLE;
			end else if (state == MATCHED) begin
				next_state = BYTE1;
			end else begin
				next_state = seq_state_t'(state + 4'd1); // BYTE7 steps to MATCHED
			end
		end
	end

	always_ff @(posedge axi_clk) begin
		if (!axi_rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign seq_hit = (state == MATCHED);

	// hit only after the last magic byte was strobed in BYTE7
	a_hit_after_byte7: assert property (@(posedge axi_clk) disable iff (!axi_rst_n)
		seq_hit |-> $past(state == BYTE7 && rx_valid && rx_byte == RESET_SEQUENCE[63:56]));

endmodule

//--- hw/uart_reset_driver.sv
`timescale 1ns/1ps

module uart_reset_driver #(
	parameter int NUM_UARTS   = 4,
	parameter int HOLD_CYCLES = 16
) (
	input  logic                 axi_clk,
	input  logic                 axi_rst_n,
	input  logic [NUM_UARTS-1:0] seq_hit,
	output logic [NUM_UARTS-1:0] uart_rst_n,
	output logic [NUM_UARTS-1:0] reset_seen
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt [NUM_UARTS];

	// ********************
	// hold counters
	// ********************

	always_ff @(posedge axi_clk) begin
		if (!axi_rst_n) begin
			for (int i = 0; i < NUM_UARTS; i++)
				hold_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_UARTS; i++) begin
				if (seq_hit[i])
					hold_cnt[i] <= CNT_W'(HOLD_CYCLES); // restart on a new hit
				else if (hold_cnt[i] != '0)
					hold_cnt[i] <= hold_cnt[i] - CNT_W'(1);
			end
		end
	end

	// reset held while the count runs
	always_comb begin
		for (int i = 0; i < NUM_UARTS; i++)
			uart_rst_n[i] = (hold_cnt[i] == '0);
	end

	// ********************
	// sticky flags
	// ********************

	always_ff @(posedge axi_clk) begin
		if (!axi_rst_n) begin
			reset_seen <= '0;
		end else begin
			reset_seen <= reset_seen | seq_hit;
		end
	end

	for (genvar g = 0; g < NUM_UARTS; g++) begin : g_chk
		// every pulse leaves its flag behind
		a_low_has_flag: assert property (@(posedge axi_clk) disable iff (!axi_rst_n)
			!uart_rst_n[g] |-> reset_seen[g]);
	end

endmodule

//--- hw/uart_reset_snoop_top.sv
`timescale 1ns/1ps

module uart_reset_snoop_top
	import uart_snoop_pkg::*;
#(
	parameter int NUM_UARTS   = 4, // 1 to 8
	parameter int HOLD_CYCLES = 16
) (
	input  logic                  axi_clk,
	input  logic                  axi_rst_n,

	// read address channel, observed only
	input  logic [AXI_ADDR_W-1:0] axi_araddr,
	input  logic                  axi_arvalid,
	input  logic                  axi_arready,

	// read data channel, observed only
	input  logic [31:0]           axi_rdata,
	input  logic                  axi_rvalid,
	input  logic                  axi_rready,

	output logic [NUM_UARTS-1:0]  uart_rst_n,
	output logic [NUM_UARTS-1:0]  reset_seen
);

	logic [7:0]           rx_byte;
	logic [NUM_UARTS-1:0] rx_strobe;
	logic [NUM_UARTS-1:0] seq_hit;

	// ********************
	// RBR read snoop
	// ********************

	rbr_read_tracker #(
		.NUM_UARTS(NUM_UARTS)
	) u_tracker (
		.axi_clk    (axi_clk),
		.axi_rst_n  (axi_rst_n),
		.axi_araddr (axi_araddr),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rdata  (axi_rdata),
		.axi_rvalid (axi_rvalid),
		.axi_rready (axi_rready),
		.rx_byte    (rx_byte),
		.rx_strobe  (rx_strobe)
	);

	// one matcher per UART, all share rx_byte
	for (genvar i = 0; i < NUM_UARTS; i++) begin : g_matcher
		reset_seq_matcher u_matcher (
			.axi_clk  (axi_clk),
			.axi_rst_n(axi_rst_n),
			.rx_byte  (rx_byte),
			.rx_valid (rx_strobe[i]),
			.seq_hit  (seq_hit[i])
		);
	end

	// ********************
	// reset outputs
	// ********************

	uart_reset_driver #(
		.NUM_UARTS  (NUM_UARTS),
		.HOLD_CYCLES(HOLD_CYCLES)
	) u_driver (
		.axi_clk   (axi_clk),
		.axi_rst_n (axi_rst_n),
		.seq_hit   (seq_hit),
		.uart_rst_n(uart_rst_n),
		.reset_seen(reset_seen)
	);

endmodule

//--- test/tb_snoop_table.svh
`ifndef TB_SNOOP_TABLE_SVH
`define TB_SNOOP_TABLE_SVH

// ********************
// read table
// ********************

// flags bit 0 swaps data for filler, bit 1 adds an AR while the read is pending
typedef struct packed {
	logic [2:0]  uart;     // window index
	logic [12:0] off;      // register offset
	logic [7:0]  data;     // low byte of rdata
	logic [3:0]  stall;    // rready low cycles
	logic [3:0]  gap;      // idle cycles after R
	logic [1:0]  flags;
	logic [3:0]  exp_seen; // reset_seen after the row
} row_t;

localparam int NUM_ROWS = 63;

localparam row_t ROWS [NUM_ROWS] = '{
	// uart 0, plain sequence
	'{3'd0, `UART_RBR, 8'h34, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'h27, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'haf, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'h13, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'h72, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0000},
	'{3'd0, `UART_RBR, 8'h9a, 4'd0, 4'd3, 2'b00, 4'b0001},
	// uart 1, byte 0 arrives in place of byte 3
	'{3'd1, `UART_RBR, 8'h34, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h27, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h34, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h27, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'haf, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h13, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h72, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h9a, 4'd0, 4'd3, 2'b00, 4'b0001}, // no reset here
	'{3'd1, `UART_RBR, 8'h34, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h27, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'haf, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h13, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h72, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0001},
	'{3'd1, `UART_RBR, 8'h9a, 4'd0, 4'd3, 2'b00, 4'b0011},
	// uart 2 with reads that must be ignored
	'{3'd2, `UART_RBR, 8'h34, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd2, `UART_LSR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd2, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd6, `UART_RBR, 8'h00, 4'd0, 4'd3, 2'b01, 4'b0011}, // low bits alias uart 2
	'{3'd2, `UART_RBR, 8'h27, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd2, `UART_RBR, 8'haf, 4'd0, 4'd3, 2'b10, 4'b0011},
	'{3'd2, `UART_LSR, 8'h00, 4'd0, 4'd3, 2'b01, 4'b0011},
	'{3'd2, `UART_RBR, 8'h13, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd2, `UART_RBR, 8'h72, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd6, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd2, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0011},
	'{3'd2, `UART_RBR, 8'h9a, 4'd0, 4'd3, 2'b00, 4'b0111},
	// uarts 3 and 0 interleaved, some with rready stalls
	'{3'd3, `UART_RBR, 8'h34, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'h34, 4'd2, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'h8f, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'h27, 4'd1, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'h27, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'haf, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'haf, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'h13, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'h13, 4'd3, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'h72, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'h72, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd0, `UART_RBR, 8'h33, 4'd0, 4'd3, 2'b00, 4'b0111},
	'{3'd3, `UART_RBR, 8'h9a, 4'd6, 4'd3, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h9a, 4'd0, 4'd0, 2'b00, 4'b1111},
	// back to back on uart 0, hit lands inside the hold
	'{3'd0, `UART_RBR, 8'h34, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h8f, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h27, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'haf, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h13, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h72, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h33, 4'd0, 4'd0, 2'b00, 4'b1111},
	'{3'd0, `UART_RBR, 8'h9a, 4'd0, 4'd2, 2'b00, 4'b1111}
};

`endif

//--- test/tb_uart_reset_snoop.sv
`timescale 1ns/1ps
`include "uart16550_define.svh"

module tb_uart_reset_snoop
	import uart_snoop_pkg::*;
();

	localparam int NUM_UARTS   = 4;
	localparam int HOLD_CYCLES = 16;
	localparam int CLK_HALF    = 4;

	`include "tb_snoop_table.svh"

	logic                  axi_clk;
	logic                  axi_rst_n;
	logic [AXI_ADDR_W-1:0] axi_araddr;
	logic                  axi_arvalid;
	logic                  axi_arready;
	logic [31:0]           axi_rdata;
	logic                  axi_rvalid;
	logic                  axi_rready;
	logic [NUM_UARTS-1:0]  uart_rst_n;
	logic [NUM_UARTS-1:0]  reset_seen;

	// reference model state
	logic       m_pending;
	logic [2:0] m_pidx;
	logic       m_strobe;
	logic [2:0] m_sidx;
	logic [7:0] m_byte;
	int         m_pos [8]; // next expected byte per window
	logic [7:0] m_hit;
	int         m_cnt [8];
	logic [7:0] m_seen;

	int          row_err;
	int          cyc_err;
	int          tmo_cnt;
	logic        checking;
	logic [31:0] rng;

	uart_reset_snoop_top #(
		.NUM_UARTS  (NUM_UARTS),
		.HOLD_CYCLES(HOLD_CYCLES)
	) dut0 (
		.axi_clk    (axi_clk),
		.axi_rst_n  (axi_rst_n),
		.axi_araddr (axi_araddr),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rdata  (axi_rdata),
		.axi_rvalid (axi_rvalid),
		.axi_rready (axi_rready),
		.uart_rst_n (uart_rst_n),
		.reset_seen (reset_seen)
	);

	initial begin
		axi_clk = 1'b0;
		forever #(CLK_HALF) axi_clk = ~axi_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] seq_byte(input int k);
		return RESET_SEQUENCE[k*8 +: 8];
	endfunction

	// random byte that cannot advance the matcher of window u
	function automatic logic [7:0] pick_filler(input logic [2:0] u);
		logic [7:0] b;
		rng = xorshift32(rng);
		b = rng[7:0];
		if (b == seq_byte(m_pos[u]))
			b = ~b;
		return b;
	endfunction

	// ********************
	// reference model
	// ********************

	// stages evaluated back to front so each sees last cycle's values
	always @(posedge axi_clk) begin
		if (!axi_rst_n) begin
			m_pending = 1'b0;
			m_strobe  = 1'b0;
			m_hit     = '0;
			m_seen    = '0;
			for (int u = 0; u < 8; u++) begin
				m_pos[u] = 0;
				m_cnt[u] = 0;
			end
		end else begin
			for (int u = 0; u < 8; u++) begin
				if (m_hit[u]) begin
					m_cnt[u]  = HOLD_CYCLES;
					m_seen[u] = 1'b1;
				end else if (m_cnt[u] > 0) begin
					m_cnt[u] = m_cnt[u] - 1;
				end
			end
			m_hit = '0;
			if (m_strobe) begin
				if (m_byte != seq_byte(m_pos[m_sidx])) begin
					m_pos[m_sidx] = 0; // wrong byte is not retried as byte 0
				end else if (m_pos[m_sidx] == 7) begin
					m_pos[m_sidx] = 0;
					m_hit[m_sidx] = 1'b1;
				end else begin
					m_pos[m_sidx] = m_pos[m_sidx] + 1;
				end
			end
			m_strobe = m_pending && axi_rvalid && axi_rready;
			m_sidx   = m_pidx;
			m_byte   = axi_rdata[7:0];
			if (m_pending) begin
				if (axi_rvalid && axi_rready)
					m_pending = 1'b0;
			end else if (axi_arvalid && axi_arready
					&& axi_araddr[UART_SEL_LSB-1:0] == `UART_RBR
					&& int'(axi_araddr[AXI_ADDR_W-1:UART_SEL_LSB]) < NUM_UARTS) begin
				m_pending = 1'b1;
				m_pidx    = axi_araddr[AXI_ADDR_W-1:UART_SEL_LSB];
			end
		end
	end

	task automatic check_outputs();
		logic [NUM_UARTS-1:0] exp_rst;
		for (int u = 0; u < NUM_UARTS; u++)
			exp_rst[u] = (m_cnt[u] == 0);
		if (uart_rst_n !== exp_rst) begin
			$display("** Error at %0d ns: uart_rst_n expected %b, got %b",
				$time, exp_rst, uart_rst_n);
			cyc_err++;
		end
		if (reset_seen !== m_seen[NUM_UARTS-1:0]) begin
			$display("** Error at %0d ns: reset_seen expected %b, got %b",
				$time, m_seen[NUM_UARTS-1:0], reset_seen);
			cyc_err++;
		end
	endtask

	always @(negedge axi_clk) begin
		if (checking)
			check_outputs();
	end

	// ********************
	// AXI read driver
	// ********************

	task automatic next_cycle();
		@(posedge axi_clk);
		#1;
	endtask

	task automatic run_row(input int idx, input row_t r);
		logic [7:0] data;
		axi_araddr  = {r.uart, r.off};
		axi_arvalid = 1'b1;
		axi_arready = 1'b1;
		next_cycle();
		if (r.flags[1]) begin
			axi_araddr = {r.uart + 3'd1, `UART_RBR}; // lands while pending
			next_cycle();
		end
		axi_arvalid = 1'b0;
		axi_arready = 1'b0;
		data = r.flags[0] ? pick_filler(r.uart) : r.data;
		rng = xorshift32(rng);
		axi_rdata  = {rng[31:8], data};
		axi_rvalid = 1'b1;
		axi_rready = 1'b0;
		for (int s = 0; s < int'(r.stall); s++)
			next_cycle();
		axi_rready = 1'b1;
		next_cycle();
		axi_rvalid = 1'b0;
		axi_rready = 1'b0;
		repeat (r.gap) next_cycle();
		if (reset_seen !== r.exp_seen) begin
			$display("** Error at %0d ns: reset_seen after row %0d expected %b, got %b",
				$time, idx, r.exp_seen, reset_seen);
			row_err++;
		end
	endtask

	task automatic wait_reset_pulse(input int limit);
		int n;
		n = 0;
		while (uart_rst_n == '1 && n < limit) begin
			next_cycle();
			n++;
		end
		if (uart_rst_n == '1) begin
			$display("timeout: no UART reset pulse within %0d cycles", limit);
			tmo_cnt++;
		end
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin
		axi_rst_n   = 1'b0;
		axi_araddr  = '0;
		axi_arvalid = 1'b0;
		axi_arready = 1'b0;
		axi_rdata   = '0;
		axi_rvalid  = 1'b0;
		axi_rready  = 1'b0;
		rng      = 32'd86846;
		row_err  = 0;
		cyc_err  = 0;
		tmo_cnt  = 0;
		checking = 1'b0;
		repeat (2) @(posedge axi_clk);
		#1;
		axi_rst_n = 1'b1;
		checking  = 1'b1;

		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i, ROWS[i]);

		// bus reset while uart 0 is still held
		wait_reset_pulse(8);
		axi_rst_n = 1'b0;
		repeat (2) next_cycle();
		axi_rst_n = 1'b1;
		if (uart_rst_n !== '1) begin
			$display("** Error at %0d ns: uart_rst_n expected %b, got %b",
				$time, {NUM_UARTS{1'b1}}, uart_rst_n);
			row_err++;
		end
		if (reset_seen !== '0) begin
			$display("** Error at %0d ns: reset_seen expected %b, got %b",
				$time, {NUM_UARTS{1'b0}}, reset_seen);
			row_err++;
		end
		repeat (4) next_cycle();
		checking = 1'b0;

		$display("row errors %0d, cycle errors %0d, timeouts %0d", row_err, cyc_err, tmo_cnt);
		if (row_err == 0 && cyc_err == 0 && tmo_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
+incdir+test
hw/uart_snoop_pkg.sv
hw/rbr_read_tracker.sv
hw/reset_seq_matcher.sv
hw/uart_reset_driver.sv
hw/uart_reset_snoop_top.sv
test/tb_uart_reset_snoop.sv

//--- run.sh
#!/bin/sh
# build and run the snoop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_uart_reset_snoop \
	-Mdir obj_dir

out=$(./obj_dir/Vtb_uart_reset_snoop)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
